/* ps2_config.svh */
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// Consecutive equal samples of the synchronised PS/2 clock
// needed before the filter accepts a new level
`define PS2_FILTER_LEN 8

// System cycles without a falling edge before a partial
// frame is dropped, also the transmit watchdog
`define PS2_RX_TIMEOUT 2000

// System cycles the host holds the clock low
// ahead of its request-to-send start bit
`define PS2_INHIBIT_CYCLES 400

`endif

/* ps2_pkg.sv */
package ps2_pkg;

  // 11-bit PS/2 frame, start bit in bit 0
  // Raw view for shifting, field view for checks and building
  typedef union packed {
    logic [10:0] raw;
    struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;
      logic       start;
    } f;
  } ps2_frame_u;

  // Keyboard bring-up sequence
  typedef enum logic [2:0] {
    WAIT_BAT,
    SEND_LEDS,
    WAIT_ACK_LEDS,
    SEND_LED_VAL,
    WAIT_ACK_VAL,
    SEND_ENABLE,
    WAIT_ACK_EN,
    READY
  } init_state_e;

  // Host commands
  localparam logic [7:0] CMD_SET_LEDS = 8'hED;
  localparam logic [7:0] CMD_LED_OFF  = 8'h00;
  localparam logic [7:0] CMD_ENABLE   = 8'hF4;

  // Keyboard responses
  localparam logic [7:0] RSP_BAT_OK = 8'hAA;
  localparam logic [7:0] RSP_ACK    = 8'hFA;

endpackage

/* ps2_clk_filter.sv */
`timescale 1ns/10ps
`include "ps2_config.svh"

module ps2_clk_filter (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ps2_clk_i,
  output logic clk_fall_o
);

  localparam int CNT_W = $clog2(`PS2_FILTER_LEN);

  // Two-flop synchroniser
  logic sync1_q;
  logic sync2_q;
  // Run length of samples differing from the accepted level
  logic [CNT_W-1:0] cnt_q;
  // Accepted level and its copy one cycle back
  logic level_q;
  logic level_d_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Line idles high when released
      sync1_q    <= 1'b1;
      sync2_q    <= 1'b1;
      cnt_q      <= '0;
      level_q    <= 1'b1;
      level_d_q  <= 1'b1;
      clk_fall_o <= 1'b0;
    end else begin
      sync1_q <= ps2_clk_i;
      sync2_q <= sync1_q;
      // A single matching sample restarts the run
      if (sync2_q == level_q) begin
        cnt_q <= '0;
      end else if (cnt_q == CNT_W'(`PS2_FILTER_LEN - 1)) begin
        // Last of the equal samples, take the new level
        level_q <= sync2_q;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      level_d_q <= level_q;
      // One-cycle pulse on accepted 1 -> 0
      clk_fall_o <= level_d_q & ~level_q;
    end
  end

endmodule

/* ps2_rx.sv */
`timescale 1ns/10ps
`include "ps2_config.svh"

module ps2_rx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       ps2_data_i,
  input  logic       clk_fall_i,
  input  logic       tx_busy_i,
  output logic       rx_valid_o,
  output logic       rx_err_o,
  output logic [7:0] rx_byte_o
);

  localparam int TMR_W = $clog2(`PS2_RX_TIMEOUT + 1);

  ps2_pkg::ps2_frame_u frame_q;
  logic [3:0]       bit_cnt_q;
  logic [TMR_W-1:0] timer_q;
  logic             data_s1_q;
  logic             data_s2_q;
  logic             frame_full;
  logic             frame_ok;
  logic             expire;

  assign frame_full = (bit_cnt_q == 4'd11);
  // Start low, stop high, odd count of ones over data and parity
  assign frame_ok   = ~frame_q.f.start & frame_q.f.stop &
                      (^{frame_q.f.parity, frame_q.f.data});
  // Partial frame with no edge for the whole timeout
  assign expire     = (bit_cnt_q != 4'd0) && !frame_full && (timer_q == '0);
  // Byte stays put until the next frame starts shifting
  assign rx_byte_o  = frame_q.f.data;

  // Bits arrive LSB first, so shift in from the top
  always_ff @(posedge clk_i) begin
    if (clk_fall_i && !tx_busy_i && !frame_full) begin
      frame_q.raw <= {data_s2_q, frame_q.raw[10:1]};
    end else if (expire) begin
      frame_q.raw <= '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_s1_q  <= 1'b1;
      data_s2_q  <= 1'b1;
      bit_cnt_q  <= 4'd0;
      timer_q    <= '0;
      rx_valid_o <= 1'b0;
      rx_err_o   <= 1'b0;
    end else begin
      data_s1_q  <= ps2_data_i;
      data_s2_q  <= data_s1_q;
      rx_valid_o <= 1'b0;
      rx_err_o   <= 1'b0;
      if (tx_busy_i) begin
        // Own transmission on the bus, ignore it
        bit_cnt_q <= 4'd0;
      end else if (frame_full) begin
        rx_valid_o <= frame_ok;
        rx_err_o   <= ~frame_ok;
        bit_cnt_q  <= 4'd0;
      end else if (clk_fall_i) begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
        timer_q   <= TMR_W'(`PS2_RX_TIMEOUT);
      end else if (expire) begin
        // Drop silently
        bit_cnt_q <= 4'd0;
      end else if (bit_cnt_q != 4'd0) begin
        timer_q <= timer_q - 1'b1;
      end
    end
  end

endmodule

/* ps2_tx.sv */
`timescale 1ns/10ps
`include "ps2_config.svh"

module ps2_tx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       ps2_data_i,
  input  logic       clk_fall_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       ps2_clk_drive_low_o,
  output logic       ps2_data_drive_low_o,
  output logic       tx_busy_o,
  output logic       tx_done_o,
  output logic       tx_ack_o
);

  localparam int TMR_MAX = (`PS2_RX_TIMEOUT > `PS2_INHIBIT_CYCLES) ?
                           `PS2_RX_TIMEOUT : `PS2_INHIBIT_CYCLES;
  localparam int TMR_W   = $clog2(TMR_MAX + 1);

  typedef enum logic [1:0] {
    IDLE,
    INHIBIT,
    SHIFT
  } tx_state_e;

  tx_state_e           state_q;
  ps2_pkg::ps2_frame_u frame_q;
  // Inhibit length first, then edge watchdog
  logic [TMR_W-1:0]    timer_q;
  logic [3:0]          bit_cnt_q;
  logic                clk_low_q;
  logic                data_low_q;
  logic                data_s1_q;
  logic                data_s2_q;

  assign ps2_clk_drive_low_o  = clk_low_q;
  assign ps2_data_drive_low_o = data_low_q;
  assign tx_busy_o            = (state_q != IDLE);

  // Frame build on start, then shift one bit per device edge
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && tx_start_i) begin
      frame_q.f.start  <= 1'b0;
      frame_q.f.data   <= tx_byte_i;
      frame_q.f.parity <= ~^tx_byte_i;
      frame_q.f.stop   <= 1'b1;
    end else if (state_q == SHIFT && clk_fall_i) begin
      frame_q.raw <= {1'b1, frame_q.raw[10:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      timer_q    <= '0;
      bit_cnt_q  <= 4'd0;
      clk_low_q  <= 1'b0;
      data_low_q <= 1'b0;
      data_s1_q  <= 1'b1;
      data_s2_q  <= 1'b1;
      tx_done_o  <= 1'b0;
      tx_ack_o   <= 1'b0;
    end else begin
      data_s1_q <= ps2_data_i;
      data_s2_q <= data_s1_q;
      tx_done_o <= 1'b0;
      tx_ack_o  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (tx_start_i) begin
            // Pull clock low to inhibit the device
            state_q   <= INHIBIT;
            timer_q   <= TMR_W'(`PS2_INHIBIT_CYCLES);
            clk_low_q <= 1'b1;
          end
        end
        INHIBIT: begin
          if (timer_q == '0) begin
            // Request to send: start bit low, hand clock back
            state_q    <= SHIFT;
            timer_q    <= TMR_W'(`PS2_RX_TIMEOUT);
            bit_cnt_q  <= 4'd0;
            clk_low_q  <= 1'b0;
            data_low_q <= ~frame_q.f.start;
          end else begin
            timer_q <= timer_q - 1'b1;
          end
        end
        SHIFT: begin
          if (clk_fall_i) begin
            timer_q <= TMR_W'(`PS2_RX_TIMEOUT);
            if (bit_cnt_q == 4'd10) begin
              // 11th edge, device pulls data low to acknowledge
              state_q   <= IDLE;
              tx_done_o <= 1'b1;
              tx_ack_o  <= ~data_s2_q;
            end else begin
              // Data bits, parity, then released stop level
              bit_cnt_q  <= bit_cnt_q + 4'd1;
              data_low_q <= ~frame_q.raw[1];
            end
          end else if (timer_q == '0) begin
            // Device stopped clocking
            state_q    <= IDLE;
            data_low_q <= 1'b0;
            tx_done_o  <= 1'b1;
          end else begin
            timer_q <= timer_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* ps2_init_seq.sv */
`timescale 1ns/10ps

module ps2_init_seq (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rx_valid_i,
  input  logic       tx_busy_i,
  input  logic       tx_done_i,
  input  logic       tx_ack_i,
  input  logic [7:0] rx_byte_i,
  output logic       tx_start_o,
  output logic [7:0] tx_byte_o,
  output logic       key_valid_o,
  output logic       kbd_ready_o,
  output logic [7:0] key_code_o
);

  ps2_pkg::init_state_e state_q;
  logic                 send_state;
  logic                 cmd_issue;
  logic                 bat_seen;
  logic                 ack_seen;
  logic                 tx_nak;
  logic [7:0]           cmd_byte;

  assign send_state = (state_q == ps2_pkg::SEND_LEDS) ||
                      (state_q == ps2_pkg::SEND_LED_VAL) ||
                      (state_q == ps2_pkg::SEND_ENABLE);
  // Transmitter free, fire the command of this state
  assign cmd_issue  = send_state && !tx_busy_i;
  assign bat_seen   = rx_valid_i && (rx_byte_i == ps2_pkg::RSP_BAT_OK);
  assign ack_seen   = rx_valid_i && (rx_byte_i == ps2_pkg::RSP_ACK);
  // Device never pulled data low on the ack edge
  assign tx_nak     = tx_done_i && !tx_ack_i;
  assign kbd_ready_o = (state_q == ps2_pkg::READY);

  always_comb begin
    case (state_q)
      ps2_pkg::SEND_LED_VAL: cmd_byte = ps2_pkg::CMD_LED_OFF;
      ps2_pkg::SEND_ENABLE:  cmd_byte = ps2_pkg::CMD_ENABLE;
      default:               cmd_byte = ps2_pkg::CMD_SET_LEDS;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (cmd_issue) begin
      tx_byte_o <= cmd_byte;
    end
    if (rx_valid_i) begin
      key_code_o <= rx_byte_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ps2_pkg::WAIT_BAT;
      tx_start_o  <= 1'b0;
      key_valid_o <= 1'b0;
    end else begin
      tx_start_o  <= 1'b0;
      key_valid_o <= 1'b0;
      if (bat_seen) begin
        // Keyboard reset itself, start bring-up over
        state_q <= ps2_pkg::SEND_LEDS;
      end else begin
        case (state_q)
          ps2_pkg::SEND_LEDS: begin
            if (cmd_issue) begin
              tx_start_o <= 1'b1;
              state_q    <= ps2_pkg::WAIT_ACK_LEDS;
            end
          end
          ps2_pkg::WAIT_ACK_LEDS: begin
            if (tx_nak) state_q <= ps2_pkg::SEND_LEDS;
            else if (ack_seen) state_q <= ps2_pkg::SEND_LED_VAL;
          end
          ps2_pkg::SEND_LED_VAL: begin
            if (cmd_issue) begin
              tx_start_o <= 1'b1;
              state_q    <= ps2_pkg::WAIT_ACK_VAL;
            end
          end
          ps2_pkg::WAIT_ACK_VAL: begin
            if (tx_nak) state_q <= ps2_pkg::SEND_LEDS;
            else if (ack_seen) state_q <= ps2_pkg::SEND_ENABLE;
          end
          ps2_pkg::SEND_ENABLE: begin
            if (cmd_issue) begin
              tx_start_o <= 1'b1;
              state_q    <= ps2_pkg::WAIT_ACK_EN;
            end
          end
          ps2_pkg::WAIT_ACK_EN: begin
            if (tx_nak) state_q <= ps2_pkg::SEND_LEDS;
            else if (ack_seen) state_q <= ps2_pkg::READY;
          end
          // Scan codes go straight out, AA already caught above
          ps2_pkg::READY: key_valid_o <= rx_valid_i;
          default: state_q <= state_q;
        endcase
      end
    end
  end

endmodule

/* ps2_host_top.sv */
`timescale 1ns/10ps

module ps2_host_top (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  output logic       ps2_clk_drive_low_o,
  output logic       ps2_data_drive_low_o,
  output logic       key_valid_o,
  output logic       kbd_ready_o,
  output logic       rx_err_o,
  output logic [7:0] key_code_o
);

  // Filtered falling edge, shared by both directions
  logic       clk_fall;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       tx_done;
  logic       tx_ack;

  ps2_clk_filter ps2_clk_filter_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ps2_clk_i  (ps2_clk_i),
    .clk_fall_o (clk_fall)
  );

  // Device to host
  ps2_rx ps2_rx_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ps2_data_i (ps2_data_i),
    .clk_fall_i (clk_fall),
    .tx_busy_i  (tx_busy),
    .rx_valid_o (rx_valid),
    .rx_err_o   (rx_err_o),
    .rx_byte_o  (rx_byte)
  );

  // Host to device
  ps2_tx ps2_tx_inst (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .ps2_data_i           (ps2_data_i),
    .clk_fall_i           (clk_fall),
    .tx_start_i           (tx_start),
    .tx_byte_i            (tx_byte),
    .ps2_clk_drive_low_o  (ps2_clk_drive_low_o),
    .ps2_data_drive_low_o (ps2_data_drive_low_o),
    .tx_busy_o            (tx_busy),
    .tx_done_o            (tx_done),
    .tx_ack_o             (tx_ack)
  );

  ps2_init_seq ps2_init_seq_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rx_valid_i  (rx_valid),
    .tx_busy_i   (tx_busy),
    .tx_done_i   (tx_done),
    .tx_ack_i    (tx_ack),
    .rx_byte_i   (rx_byte),
    .tx_start_o  (tx_start),
    .tx_byte_o   (tx_byte),
    .key_valid_o (key_valid_o),
    .kbd_ready_o (kbd_ready_o),
    .key_code_o  (key_code_o)
  );

endmodule

/* tb_ps2_kbd_model.sv */
`timescale 1ns/10ps
`include "ps2_config.svh"

// Behavioural PS/2 keyboard, device side of the bus
module tb_ps2_kbd_model #(
  parameter int HALF_CYC = 60
) (
  input  logic clk_i,
  input  logic ps2_clk_i,
  input  logic ps2_data_i,
  output logic clk_release_o,
  output logic data_release_o
);

  // Open-drain outputs, 1 lets the line float high
  logic        clk_rel = 1'b1;
  logic        data_rel = 1'b1;
  // Current low stretch of the resolved clock
  int unsigned clk_low_run = 0;
  logic [7:0]  last_byte = 8'h00;
  // First failed frame check, picked up by the testbench top
  bit          fault = 1'b0;
  string       fault_msg = "";

  assign clk_release_o  = clk_rel;
  assign data_release_o = data_rel;

  // Counted on the rising edge, ahead of the host's own line updates
  always @(posedge clk_i) begin
    if (ps2_clk_i) begin
      clk_low_run <= 0;
    end else begin
      clk_low_run <= clk_low_run + 1;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  function automatic void record_fault(input string msg);
    if (!fault) begin
      fault     = 1'b1;
      fault_msg = msg;
    end
  endfunction

  // Device to host frame, optionally bad parity or cut short
  task automatic send_byte(input logic [7:0] value, input bit bad_parity, input int n_bits);
    ps2_pkg::ps2_frame_u frame;
    int k;
    frame.f.start  = 1'b0;
    frame.f.data   = value;
    frame.f.parity = ~^value ^ bad_parity;
    frame.f.stop   = 1'b1;
    for (k = 0; k < n_bits; k++) begin
      // Data set up while clock high, host samples on the fall
      data_rel = frame.raw[k];
      wait_cycles(HALF_CYC);
      clk_rel = 1'b0;
      wait_cycles(HALF_CYC);
      clk_rel = 1'b1;
    end
    data_rel = 1'b1;
    wait_cycles(HALF_CYC);
  endtask

  // Host to device frame after inhibit and request to send
  task automatic recv_host_frame(input bit give_ack);
    ps2_pkg::ps2_frame_u frame;
    int unsigned inhibit_len;
    int k;
    @(negedge clk_i);
    while (ps2_data_i !== 1'b0) begin
      @(negedge clk_i);
    end
    // Low stretch that ended when the start bit appeared
    inhibit_len = clk_low_run;
    assert (inhibit_len >= `PS2_INHIBIT_CYCLES)
      else record_fault($sformatf("host held the clock low only %0d cycles before its start bit",
                                  inhibit_len));
    frame.raw = '1;
    wait_cycles(HALF_CYC);
    // Start bit as it stands just before the first pulse
    frame.raw[0] = ps2_data_i;
    // Pulses 1 to 10, device reads on the rising edge
    for (k = 1; k <= 10; k++) begin
      clk_rel = 1'b0;
      wait_cycles(HALF_CYC);
      frame.raw[k] = ps2_data_i;
      clk_rel = 1'b1;
      if (k == 10 && give_ack) begin
        data_rel = 1'b0;
      end
      wait_cycles(HALF_CYC);
    end
    // Acknowledge pulse, data held low only when acking
    clk_rel = 1'b0;
    wait_cycles(HALF_CYC);
    clk_rel  = 1'b1;
    data_rel = 1'b1;
    wait_cycles(HALF_CYC);
    last_byte = frame.f.data;
    assert (frame.f.start == 1'b0)
      else record_fault($sformatf("mismatch host start bit: got %h expected 0", frame.f.start));
    // Odd parity, ones over data and parity add up to an odd count
    assert ($countones({frame.f.parity, frame.f.data}) % 2 == 1)
      else record_fault($sformatf("mismatch host parity bit: got %h expected %h",
                                  frame.f.parity, ~frame.f.parity));
    assert (frame.f.stop == 1'b1)
      else record_fault($sformatf("mismatch host stop bit: got %h expected 1", frame.f.stop));
  endtask

  task automatic get_last_byte(output logic [7:0] value);
    value = last_byte;
  endtask

endmodule

/* tb_ps2_host.sv */
`timescale 1ns/10ps
`include "ps2_config.svh"

module tb_ps2_host;

  localparam int HALF_CYC  = 60;
  localparam int N_KEYS    = 20;
  // Scenario lengths in system cycles
  localparam int FRAME_CYC = 22 * HALF_CYC;
  localparam int INIT_CYC  = 7 * FRAME_CYC + 3 * `PS2_INHIBIT_CYCLES;
  localparam int KEYS_CYC  = N_KEYS * FRAME_CYC;
  localparam int PAR_CYC   = 2 * FRAME_CYC;
  localparam int TRUNC_CYC = 2 * FRAME_CYC + `PS2_RX_TIMEOUT + 4 * HALF_CYC;
  localparam int RETRY_CYC = 8 * FRAME_CYC + 4 * `PS2_INHIBIT_CYCLES;
  localparam int WATCHDOG_CYC = 2 * (INIT_CYC + KEYS_CYC + PAR_CYC + TRUNC_CYC + RETRY_CYC);

  logic        clk;
  logic        rst_n;
  logic        ps2_clk;
  logic        ps2_data;
  logic        host_clk_dl;
  logic        host_data_dl;
  logic        kbd_clk_rel;
  logic        kbd_data_rel;
  logic        key_valid_o;
  logic        kbd_ready_o;
  logic        rx_err_o;
  logic [7:0]  key_code_o;
  // Scan codes sent but not yet seen on key_code_o
  logic [7:0]  exp_q[$];
  logic [7:0]  exp_code;
  logic [7:0]  code;
  logic [31:0] lcg_state;
  int          key_cnt = 0;
  int          err_cnt = 0;
  bit          ready_allowed = 1'b0;

  // Wired-AND open-drain bus
  assign ps2_clk  = kbd_clk_rel & ~host_clk_dl;
  assign ps2_data = kbd_data_rel & ~host_data_dl;

  ps2_host_top ps2_host_top_inst (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .ps2_clk_i            (ps2_clk),
    .ps2_data_i           (ps2_data),
    .ps2_clk_drive_low_o  (host_clk_dl),
    .ps2_data_drive_low_o (host_data_dl),
    .key_valid_o          (key_valid_o),
    .kbd_ready_o          (kbd_ready_o),
    .rx_err_o             (rx_err_o),
    .key_code_o           (key_code_o)
  );

  tb_ps2_kbd_model #(.HALF_CYC(HALF_CYC)) kbd_model_inst (
    .clk_i          (clk),
    .ps2_clk_i      (ps2_clk),
    .ps2_data_i     (ps2_data),
    .clk_release_o  (kbd_clk_rel),
    .data_release_o (kbd_data_rel)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("** FAIL **");
    $display("%s", why);
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // AA would restart bring-up, so never a scan code
  task automatic draw_scan_code(output logic [7:0] value);
    do begin
      lcg_state = lcg_next(lcg_state);
      value     = lcg_state[23:16];
    end while (value == ps2_pkg::RSP_BAT_OK);
  endtask

  task automatic check_model_fault();
    assert (!kbd_model_inst.fault) else fail_run(kbd_model_inst.fault_msg);
  endtask

  task automatic take_command(input logic [7:0] expected, input bit give_ack);
    logic [7:0] got;
    kbd_model_inst.recv_host_frame(give_ack);
    check_model_fault();
    kbd_model_inst.get_last_byte(got);
    assert (got == expected)
      else fail_run($sformatf("mismatch host command byte: got %h expected %h", got, expected));
  endtask

  task automatic wait_ready_level(input logic level);
    int n;
    n = 0;
    while (kbd_ready_o !== level && n < 4 * HALF_CYC) begin
      @(negedge clk);
      n++;
    end
    assert (kbd_ready_o === level)
      else fail_run($sformatf("mismatch kbd_ready_o: got %h expected %h", kbd_ready_o, level));
  endtask

  task automatic wait_keys_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * HALF_CYC) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else fail_run("sent scan code never showed up on key_code_o");
  endtask

  task automatic wait_err_count(input int expected);
    int n;
    n = 0;
    while (err_cnt < expected && n < 4 * HALF_CYC) begin
      @(negedge clk);
      n++;
    end
    assert (err_cnt == expected)
      else fail_run($sformatf("mismatch rx_err_o pulse count: got %h expected %h",
                              err_cnt, expected));
  endtask

  task automatic send_key(input logic [7:0] value);
    exp_q.push_back(value);
    kbd_model_inst.send_byte(value, 1'b0, 11);
    wait_keys_drained();
  endtask

  // AA, then ED / 00 / F4 each answered with FA
  task automatic bring_up(input bit drop_first_ack);
    kbd_model_inst.send_byte(ps2_pkg::RSP_BAT_OK, 1'b0, 11);
    ready_allowed = 1'b0;
    wait_ready_level(1'b0);
    if (drop_first_ack) begin
      // No ack, host must retry from ED
      take_command(ps2_pkg::CMD_SET_LEDS, 1'b0);
    end
    take_command(ps2_pkg::CMD_SET_LEDS, 1'b1);
    kbd_model_inst.send_byte(ps2_pkg::RSP_ACK, 1'b0, 11);
    take_command(ps2_pkg::CMD_LED_OFF, 1'b1);
    kbd_model_inst.send_byte(ps2_pkg::RSP_ACK, 1'b0, 11);
    take_command(ps2_pkg::CMD_ENABLE, 1'b1);
    ready_allowed = 1'b1;
    kbd_model_inst.send_byte(ps2_pkg::RSP_ACK, 1'b0, 11);
    wait_ready_level(1'b1);
  endtask

  // Key strobes against the queue, error pulses, early ready
  always @(negedge clk) begin
    if (rst_n && key_valid_o) begin
      key_cnt = key_cnt + 1;
      if (exp_q.size() == 0) begin
        fail_run($sformatf("key_valid_o pulsed with code %h while no scan code was pending",
                           key_code_o));
      end else begin
        exp_code = exp_q.pop_front();
        assert (key_code_o == exp_code)
          else fail_run($sformatf("mismatch key_code_o: got %h expected %h",
                                  key_code_o, exp_code));
      end
    end
    if (rst_n && rx_err_o) begin
      err_cnt = err_cnt + 1;
    end
    if (rst_n && !ready_allowed) begin
      assert (!kbd_ready_o) else fail_run("kbd_ready_o went high before enable was acknowledged");
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    fail_run("watchdog expired, the DUT or the keyboard model stalled");
  end

  initial begin
    rst_n     = 1'b0;
    lcg_state = 32'd71791;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (HALF_CYC) @(negedge clk);
    bring_up(1'b0);
    assert (err_cnt == 0) else fail_run("rx_err_o pulsed during keyboard bring-up");
    // Random scan codes after ready
    repeat (N_KEYS) begin
      draw_scan_code(code);
      send_key(code);
    end
    // Bad parity, then a good frame
    draw_scan_code(code);
    kbd_model_inst.send_byte(code, 1'b1, 11);
    wait_err_count(1);
    draw_scan_code(code);
    send_key(code);
    // Frame cut after 5 bits, idle past the receive timeout
    draw_scan_code(code);
    kbd_model_inst.send_byte(code, 1'b0, 5);
    repeat (`PS2_RX_TIMEOUT + 4 * HALF_CYC) @(negedge clk);
    wait_err_count(1);
    draw_scan_code(code);
    send_key(code);
    // Fresh AA while ready, first ED left without ack
    bring_up(1'b1);
    if (key_cnt != N_KEYS + 2 || err_cnt != 1 || exp_q.size() != 0) begin
      fail_run($sformatf("final counts off: %0d key strobes, %0d error pulses, %0d pending",
                         key_cnt, err_cnt, exp_q.size()));
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* files.f */
+incdir+.
ps2_pkg.sv
ps2_clk_filter.sv
ps2_rx.sv
ps2_tx.sv
ps2_init_seq.sv
ps2_host_top.sv
tb_ps2_kbd_model.sv
tb_ps2_host.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_ps2_host -o sim_ps2_host
./obj_dir/sim_ps2_host > sim.log 2>&1 || true
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
